/* design/hdmiVideoPkg.sv */
/* Shared types for the HDMI video path: pixel, colour, counter, TMDS word
   and pattern select, plus the TMDS control tokens and pattern codes */

package hdmiVideoPkg;

    //----------------------------------------------------------------------
    // Data widths
    //----------------------------------------------------------------------
    typedef logic [23:0] pixelT;    // {red, green, blue}
    typedef logic [7:0]  colorT;    // One colour component
    typedef logic [11:0] countT;    // Raster counter
    typedef logic [9:0]  tmdsWordT; // Parallel TMDS symbol
    typedef logic [1:0]  patternT;  // Pattern select

    //----------------------------------------------------------------------
    // Pattern codes
    //----------------------------------------------------------------------
    localparam patternT patSolid    = 2'd0;   // Latched solid colour
    localparam patternT patBars     = 2'd1;   // Eight vertical bars
    localparam patternT patGrid     = 2'd2;   // 8 pixel grid
    localparam patternT patGradient = 2'd3;   // Counter gradient

    //----------------------------------------------------------------------
    // TMDS control period tokens, indexed by {c1, c0}
    //----------------------------------------------------------------------
    localparam tmdsWordT ctrlToken00 = 10'b1101010100;
    localparam tmdsWordT ctrlToken01 = 10'b0010101011;
    localparam tmdsWordT ctrlToken10 = 10'b0101010100;
    localparam tmdsWordT ctrlToken11 = 10'b1010101011;

    // Full-scale component values
    localparam colorT colorMax = 8'hFF;
    localparam colorT colorMin = 8'h00;

endpackage

/* design/dispTiming.sv */
/* Display timing generator: horizontal and vertical raster counters,
   data enable, active-low syncs and the frame start pulse */

`timescale 1ns/1ns

module dispTiming #(
    parameter int hDisplay = 640,
    parameter int hFront   = 16,
    parameter int hSync    = 96,
    parameter int hBack    = 48,
    parameter int vDisplay = 480,
    parameter int vFront   = 10,
    parameter int vSync    = 2,
    parameter int vBack    = 33
)(
    input  logic               wPixelClk,
    input  logic               arstN,
    output hdmiVideoPkg::countT hCount,     // Pixel position in line
    output hdmiVideoPkg::countT vCount,     // Line position in frame
    output logic               de,          // Active video
    output logic               hsyncN,
    output logic               vsyncN,
    output logic               frameStart   // Last pixel of last line
);

    import hdmiVideoPkg::*;

    //----------------------------------------------------------------------
    // Raster geometry
    //----------------------------------------------------------------------
    localparam int hTotal = hDisplay + hFront + hSync + hBack;
    localparam int vTotal = vDisplay + vFront + vSync + vBack;

    localparam countT hLast      = countT'(hTotal - 1);
    localparam countT vLast      = countT'(vTotal - 1);
    localparam countT hDispEnd   = countT'(hDisplay);
    localparam countT vDispEnd   = countT'(vDisplay);
    localparam countT hSyncStart = countT'(hDisplay + hFront);
    localparam countT hSyncEnd   = countT'(hDisplay + hFront + hSync);
    localparam countT vSyncStart = countT'(vDisplay + vFront);
    localparam countT vSyncEnd   = countT'(vDisplay + vFront + vSync);

    countT hNext;   // Counter values for the next cycle
    countT vNext;
    logic  lineEnd;

    //----------------------------------------------------------------------
    // Next counter values
    //----------------------------------------------------------------------
    always_comb
    begin
        lineEnd = (hCount == hLast);
        hNext   = lineEnd ? '0 : countT'(hCount + 1'b1);   // Wrap at total
        vNext   = vCount;
        if (lineEnd)
        begin
            vNext = (vCount == vLast) ? '0 : countT'(vCount + 1'b1);
        end
    end

    // Flags registered from the next position, so they line up with counters
    always_ff @(posedge wPixelClk or negedge arstN)
    begin
        if (!arstN)
        begin
            hCount     <= '0;
            vCount     <= '0;
            de         <= 1'b1;     // Position 0,0 is active
            hsyncN     <= 1'b1;
            vsyncN     <= 1'b1;
            frameStart <= 1'b0;
        end
        else
        begin
            hCount     <= hNext;
            vCount     <= vNext;
            de         <= (hNext < hDispEnd) && (vNext < vDispEnd);
            hsyncN     <= !((hNext >= hSyncStart) && (hNext < hSyncEnd));
            vsyncN     <= !((vNext >= vSyncStart) && (vNext < vSyncEnd));
            frameStart <= (hNext == hLast) && (vNext == vLast);
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Horizontal sync sits inside blanking
    aHsyncInBlank : assert property (
        @(posedge wPixelClk) disable iff (!arstN)
        !(de && !hsyncN)
    );

endmodule

/* design/pixelGen.sv */
/* Pattern pixel source: frame-latched pattern select and one registered
   RGB pixel per cycle, with de and syncs delayed to stay aligned */

`timescale 1ns/1ns

module pixelGen #(
    parameter int hDisplay = 640,
    parameter int vDisplay = 480
)(
    input  logic                  wPixelClk,
    input  logic                  arstN,
    input  hdmiVideoPkg::countT   hCount,
    input  hdmiVideoPkg::countT   vCount,
    input  logic                  de,
    input  logic                  hsyncN,
    input  logic                  vsyncN,
    input  logic                  frameStart,
    input  hdmiVideoPkg::patternT patternSel,
    input  hdmiVideoPkg::pixelT   solidColor,
    output hdmiVideoPkg::pixelT   pixel,
    output logic                  pixDe,
    output logic                  pixHsyncN,
    output logic                  pixVsyncN
);

    import hdmiVideoPkg::*;

    localparam countT barWidth = countT'(hDisplay / 8);   // Eight bars per line

    patternT patLatch;      // Pattern for the current frame
    pixelT   colorLatch;    // Solid colour for the current frame
    countT   barQuot;
    logic [2:0] barIdx;
    pixelT   barColor;
    logic    gridOn;
    pixelT   nextPixel;

    //----------------------------------------------------------------------
    // Frame latch, updated only between frames
    //----------------------------------------------------------------------
    always_ff @(posedge wPixelClk or negedge arstN)
    begin
        if (!arstN)
        begin
            patLatch   <= patSolid;
            colorLatch <= '0;
        end
        else if (frameStart)
        begin
            patLatch   <= patternSel;
            colorLatch <= solidColor;
        end
    end

    //----------------------------------------------------------------------
    // Pattern generation
    //----------------------------------------------------------------------
    always_comb
    begin
        barQuot = hCount / barWidth;
        barIdx  = (barQuot > countT'(7)) ? 3'd7 : barQuot[2:0];  // Clamp last bar
        case (barIdx)
            3'd0:    barColor = {colorMax, colorMax, colorMax};    // White
            3'd1:    barColor = {colorMax, colorMax, colorMin};    // Yellow
            3'd2:    barColor = {colorMin, colorMax, colorMax};    // Cyan
            3'd3:    barColor = {colorMin, colorMax, colorMin};    // Green
            3'd4:    barColor = {colorMax, colorMin, colorMax};    // Magenta
            3'd5:    barColor = {colorMax, colorMin, colorMin};    // Red
            3'd6:    barColor = {colorMin, colorMin, colorMax};    // Blue
            default: barColor = {colorMin, colorMin, colorMin};    // Black
        endcase

        gridOn = (hCount[2:0] == 3'd0) || (vCount[2:0] == 3'd0);

        case (patLatch)
            patSolid: nextPixel = colorLatch;
            patBars:  nextPixel = barColor;
            patGrid:  nextPixel = gridOn ? {3{colorMax}} : {3{colorMin}};
            default:  nextPixel = {hCount[7:0], vCount[7:0], hCount[7:0] ^ vCount[7:0]};
        endcase
    end

    // One cycle stage, blanking forced to black
    always_ff @(posedge wPixelClk or negedge arstN)
    begin
        if (!arstN)
        begin
            pixel     <= '0;
            pixDe     <= 1'b0;
            pixHsyncN <= 1'b1;
            pixVsyncN <= 1'b1;
        end
        else
        begin
            pixel     <= de ? nextPixel : '0;
            pixDe     <= de;
            pixHsyncN <= hsyncN;
            pixVsyncN <= vsyncN;
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    aBlackInBlank : assert property (
        @(posedge wPixelClk) disable iff (!arstN)
        !pixDe |-> (pixel == '0)
    );

    // Timing generator keeps de inside the display area
    aDeInDisplay : assert property (
        @(posedge wPixelClk) disable iff (!arstN)
        de |-> ((hCount < countT'(hDisplay)) && (vCount < countT'(vDisplay)))
    );

endmodule

/* design/tmdsEncoder.sv */
/* TMDS 8b/10b channel encoder: transition minimizing, DC balancing with
   running disparity, and control tokens during blanking */

`timescale 1ns/1ns

module tmdsEncoder (
    input  logic                   wPixelClk,
    input  logic                   arstN,
    input  hdmiVideoPkg::colorT    dataIn,
    input  logic [1:0]             ctrl,       // {c1, c0}
    input  logic                   de,
    output hdmiVideoPkg::tmdsWordT tmdsWord
);

    import hdmiVideoPkg::*;

    logic [3:0]        n1d;         // Ones in input byte
    logic              useXnor;
    logic [8:0]        qm;          // Transition minimized word
    logic [3:0]        n1q;         // Ones in qm[7:0]
    logic signed [5:0] balance;     // Ones minus zeros of qm[7:0]
    logic signed [5:0] disparity;   // Running disparity
    logic signed [5:0] dispNext;
    logic signed [5:0] qm8Two;      // 2 when qm[8] set
    logic signed [5:0] qm8NotTwo;   // 2 when qm[8] clear
    tmdsWordT          encWord;
    tmdsWordT          ctrlWord;

    function automatic logic [3:0] countOnes(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++)
        begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    //----------------------------------------------------------------------
    // Stage 1: transition minimizing
    //----------------------------------------------------------------------
    always_comb
    begin
        n1d     = countOnes(dataIn);
        useXnor = (n1d > 4'd4) || ((n1d == 4'd4) && !dataIn[0]);
        qm[0]   = dataIn[0];
        for (int i = 1; i < 8; i++)
        begin
            qm[i] = useXnor ? ~(qm[i-1] ^ dataIn[i]) : (qm[i-1] ^ dataIn[i]);
        end
        qm[8] = ~useXnor;   // Set for XOR
    end

    //----------------------------------------------------------------------
    // Stage 2: DC balance
    //----------------------------------------------------------------------
    always_comb
    begin
        n1q       = countOnes(qm[7:0]);
        balance   = $signed({1'b0, n1q, 1'b0}) - 6'sd8;    // 2*n1 - 8
        qm8Two    = $signed({4'b0000, qm[8], 1'b0});
        qm8NotTwo = $signed({4'b0000, ~qm[8], 1'b0});

        if ((disparity == 6'sd0) || (balance == 6'sd0))
        begin
            // No bias either way, qm[8] picks the polarity
            encWord  = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            dispNext = qm[8] ? (disparity + balance) : (disparity - balance);
        end
        else if (((disparity > 6'sd0) && (balance > 6'sd0)) ||
                 ((disparity < 6'sd0) && (balance < 6'sd0)))
        begin
            encWord  = {1'b1, qm[8], ~qm[7:0]};    // Invert to pull back
            dispNext = disparity + qm8Two - balance;
        end
        else
        begin
            encWord  = {1'b0, qm[8], qm[7:0]};
            dispNext = disparity - qm8NotTwo + balance;
        end

        case (ctrl)
            2'b00:   ctrlWord = ctrlToken00;
            2'b01:   ctrlWord = ctrlToken01;
            2'b10:   ctrlWord = ctrlToken10;
            default: ctrlWord = ctrlToken11;
        endcase
    end

    // Output register, disparity cleared in every control period
    always_ff @(posedge wPixelClk or negedge arstN)
    begin
        if (!arstN)
        begin
            tmdsWord  <= ctrlToken00;
            disparity <= '0;
        end
        else if (de)
        begin
            tmdsWord  <= encWord;
            disparity <= dispNext;
        end
        else
        begin
            tmdsWord  <= ctrlWord;
            disparity <= '0;
        end
    end

    // Balance stays bounded and even across a whole line
    aDisparityBound : assert property (
        @(posedge wPixelClk) disable iff (!arstN)
        (disparity[0] == 1'b0) && (disparity >= -6'sd8) && (disparity <= 6'sd8)
    );

endmodule

/* design/hdmiVideoTop.sv */
/* HDMI video path top: timing generator, pattern source and the three
   TMDS channel encoders */

`timescale 1ns/1ns

module hdmiVideoTop #(
    parameter int hDisplay = 640,
    parameter int hFront   = 16,
    parameter int hSync    = 96,
    parameter int hBack    = 48,
    parameter int vDisplay = 480,
    parameter int vFront   = 10,
    parameter int vSync    = 2,
    parameter int vBack    = 33
)(
    input  logic                   wPixelClk,
    input  logic                   arstN,
    input  hdmiVideoPkg::patternT  patternSel,
    input  hdmiVideoPkg::pixelT    solidColor,
    output hdmiVideoPkg::tmdsWordT tmdsCh0,     // Blue with syncs
    output hdmiVideoPkg::tmdsWordT tmdsCh1,     // Green
    output hdmiVideoPkg::tmdsWordT tmdsCh2      // Red
);

    import hdmiVideoPkg::*;

    //----------------------------------------------------------------------
    // Raster timing
    //----------------------------------------------------------------------
    countT hCount;
    countT vCount;
    logic  de;
    logic  hsyncN;
    logic  vsyncN;
    logic  frameStart;

    dispTiming #(
        .hDisplay (hDisplay),   .hFront (hFront),
        .hSync    (hSync),      .hBack  (hBack),
        .vDisplay (vDisplay),   .vFront (vFront),
        .vSync    (vSync),      .vBack  (vBack)
    ) timing_i (
        .wPixelClk  (wPixelClk),    .arstN      (arstN),
        .hCount     (hCount),       .vCount     (vCount),
        .de         (de),           .hsyncN     (hsyncN),
        .vsyncN     (vsyncN),       .frameStart (frameStart)
    );

    //----------------------------------------------------------------------
    // Pixel source
    //----------------------------------------------------------------------
    pixelT pixel;
    logic  pixDe;
    logic  pixHsyncN;
    logic  pixVsyncN;

    pixelGen #(
        .hDisplay (hDisplay),   .vDisplay (vDisplay)
    ) pixGen_i (
        .wPixelClk  (wPixelClk),    .arstN      (arstN),
        .hCount     (hCount),       .vCount     (vCount),
        .de         (de),           .hsyncN     (hsyncN),
        .vsyncN     (vsyncN),       .frameStart (frameStart),
        .patternSel (patternSel),   .solidColor (solidColor),
        .pixel      (pixel),        .pixDe      (pixDe),
        .pixHsyncN  (pixHsyncN),    .pixVsyncN  (pixVsyncN)
    );

    //----------------------------------------------------------------------
    // TMDS channels
    //----------------------------------------------------------------------
    // Syncs carried active high as c1 = vsync, c0 = hsync
    tmdsEncoder enc0_i (
        .wPixelClk (wPixelClk),     .arstN  (arstN),
        .dataIn    (pixel[7:0]),    .ctrl   ({~pixVsyncN, ~pixHsyncN}),
        .de        (pixDe),         .tmdsWord (tmdsCh0)
    );

    tmdsEncoder enc1_i (
        .wPixelClk (wPixelClk),     .arstN  (arstN),
        .dataIn    (pixel[15:8]),   .ctrl   (2'b00),
        .de        (pixDe),         .tmdsWord (tmdsCh1)
    );

    tmdsEncoder enc2_i (
        .wPixelClk (wPixelClk),     .arstN  (arstN),
        .dataIn    (pixel[23:16]),  .ctrl   (2'b00),
        .de        (pixDe),         .tmdsWord (tmdsCh2)
    );

endmodule

/* verif/tmdsRefModel.svh */
/* Reference model functions: raster flags, pattern colours, TMDS control
   tokens and 8b/10b data encoding with running disparity */

`ifndef TMDS_REF_MODEL_SVH
`define TMDS_REF_MODEL_SVH

// Active area from raster position
function automatic bit inDisplay(input int h, input int v);
    return (h < hDisplay) && (v < vDisplay);
endfunction

function automatic bit inHsync(input int h);
    return (h >= hDisplay + hFront) && (h < hDisplay + hFront + hSync);
endfunction

function automatic bit inVsync(input int v);
    return (v >= vDisplay + vFront) && (v < vDisplay + vFront + vSync);
endfunction

//----------------------------------------------------------------------
// Pattern colour, {red, green, blue}
//----------------------------------------------------------------------
function automatic logic [23:0] patternPixel(input logic [1:0] pat,
                                             input logic [23:0] solid,
                                             input int h, input int v);
    int         bar;
    logic [7:0] hLow;
    logic [7:0] vLow;
    bar  = h / (hDisplay / 8);
    hLow = h[7:0];
    vLow = v[7:0];
    if (bar > 7)
    begin
        bar = 7;        // Leftover pixels stay black
    end
    case (pat)
        2'd0:    return solid;
        // Bar index bits pick the components: R off on bit 1, G on bit 2, B on bit 0
        2'd1:    return {{8{~bar[1]}}, {8{~bar[2]}}, {8{~bar[0]}}};
        2'd2:    return ((h % 8 == 0) || (v % 8 == 0)) ? 24'hFFFFFF : 24'h000000;
        default: return {hLow, vLow, hLow ^ vLow};
    endcase
endfunction

// Standard DVI control period codes
function automatic logic [9:0] controlWord(input logic c1, input logic c0);
    case ({c1, c0})
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

function automatic int onesIn(input logic [7:0] v);
    int n;
    int i;
    n = 0;
    for (i = 0; i < 8; i++)
    begin
        n = n + (v[i] ? 1 : 0);
    end
    return n;
endfunction

//----------------------------------------------------------------------
// 8b/10b data encoding, DVI 1.0 flow
//----------------------------------------------------------------------
function automatic logic [9:0] encodeData(input logic [7:0] d, input int dispIn,
                                          output int dispOut);
    logic [8:0] qm;
    int         ones;
    int         diff;       // Ones minus zeros of qm[7:0]
    bit         xnorMode;
    int         i;
    ones     = onesIn(d);
    xnorMode = (ones > 4) || ((ones == 4) && (d[0] == 1'b0));
    qm[0]    = d[0];
    for (i = 1; i < 8; i++)
    begin
        qm[i] = xnorMode ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
    end
    qm[8] = !xnorMode;
    diff  = 2 * onesIn(qm[7:0]) - 8;
    if ((dispIn == 0) || (diff == 0))
    begin
        dispOut = qm[8] ? (dispIn + diff) : (dispIn - diff);
        return {!qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
    end
    if (((dispIn > 0) && (diff > 0)) || ((dispIn < 0) && (diff < 0)))
    begin
        dispOut = dispIn + (qm[8] ? 2 : 0) - diff;     // Inverted word
        return {1'b1, qm[8], ~qm[7:0]};
    end
    dispOut = dispIn - (qm[8] ? 0 : 2) + diff;
    return {1'b0, qm[8], qm[7:0]};
endfunction

`endif

/* verif/hdmiVideoTb.sv */
/* HDMI video path testbench: clock, reset, file-driven pattern changes,
   cycle reference model, watchdog and per-word channel checks */

`timescale 1ns/1ns

module hdmiVideoTb;

    // Small raster of 24 x 12 = 288 cycles per frame
    localparam int hDisplay    = 16;
    localparam int hFront      = 2;
    localparam int hSync       = 3;
    localparam int hBack       = 3;
    localparam int vDisplay    = 8;
    localparam int vFront      = 1;
    localparam int vSync       = 2;
    localparam int vBack       = 1;
    localparam int hTotal      = hDisplay + hFront + hSync + hBack;
    localparam int vTotal      = vDisplay + vFront + vSync + vBack;
    localparam int frameCycles = hTotal * vTotal;
    localparam int clkPeriod   = 100;
    localparam int maxCases    = 32;

    logic        wPixelClk;
    logic        arstN;
    logic [1:0]  patternSel;
    logic [23:0] solidColor;
    logic [9:0]  tmdsCh0;
    logic [9:0]  tmdsCh1;
    logic [9:0]  tmdsCh2;

    logic [31:0] caseWords [0:4*maxCases-1];   // Four words per case
    integer      seed;
    int          errorCount;
    int          checkCount;
    int          numCases;
    int          totalFrames;
    longint      watchdogNs;
    bit          limitReady;

    // Model state
    int          mH;            // Raster position held by the counters
    int          mV;
    logic [1:0]  latPat;        // Frame latch
    logic [23:0] latColor;
    logic [23:0] s1Pixel;       // Pixel stage
    logic        s1De;
    logic        s1HsN;
    logic        s1VsN;
    logic [9:0]  expCh0;        // Encoder stage
    logic [9:0]  expCh1;
    logic [9:0]  expCh2;
    int          disp0;
    int          disp1;
    int          disp2;

    `include "tmdsRefModel.svh"

    hdmiVideoTop #(
        .hDisplay (hDisplay),   .hFront (hFront),
        .hSync    (hSync),      .hBack  (hBack),
        .vDisplay (vDisplay),   .vFront (vFront),
        .vSync    (vSync),      .vBack  (vBack)
    ) dut_i (
        .wPixelClk  (wPixelClk),    .arstN      (arstN),
        .patternSel (patternSel),   .solidColor (solidColor),
        .tmdsCh0    (tmdsCh0),      .tmdsCh1    (tmdsCh1),
        .tmdsCh2    (tmdsCh2)
    );

    always #(clkPeriod / 2) wPixelClk = ~wPixelClk;

    //----------------------------------------------------------------------
    // Reference model stepped on every rising edge
    //----------------------------------------------------------------------
    task automatic resetModel();
        mH       = 0;
        mV       = 0;
        latPat   = 2'd0;
        latColor = 24'h000000;
        s1Pixel  = 24'h000000;
        s1De     = 1'b0;
        s1HsN    = 1'b1;
        s1VsN    = 1'b1;
        expCh0   = controlWord(1'b0, 1'b0);
        expCh1   = controlWord(1'b0, 1'b0);
        expCh2   = controlWord(1'b0, 1'b0);
        disp0    = 0;
        disp1    = 0;
        disp2    = 0;
    endtask

    task automatic stepModel();
        if (s1De)   // Encoders see last cycle's pixel
        begin
            expCh0 = encodeData(s1Pixel[7:0], disp0, disp0);
            expCh1 = encodeData(s1Pixel[15:8], disp1, disp1);
            expCh2 = encodeData(s1Pixel[23:16], disp2, disp2);
        end
        else
        begin
            expCh0 = controlWord(!s1VsN, !s1HsN);   // Syncs on blue only
            expCh1 = controlWord(1'b0, 1'b0);
            expCh2 = controlWord(1'b0, 1'b0);
            disp0  = 0;
            disp1  = 0;
            disp2  = 0;
        end
        s1De    = inDisplay(mH, mV);
        s1HsN   = !inHsync(mH);
        s1VsN   = !inVsync(mV);
        s1Pixel = s1De ? patternPixel(latPat, latColor, mH, mV) : 24'h000000;
        if ((mH == hTotal - 1) && (mV == vTotal - 1))
        begin
            latPat   = patternSel;      // Frame start latches the next frame's pattern
            latColor = solidColor;
        end
        mH = (mH == hTotal - 1) ? 0 : mH + 1;
        if (mH == 0)
        begin
            mV = (mV == vTotal - 1) ? 0 : mV + 1;
        end
    endtask

    always @(posedge wPixelClk)
    begin
        if (!arstN)
        begin
            resetModel();
        end
        else
        begin
            stepModel();
        end
    end

    //----------------------------------------------------------------------
    // Word checks on the falling edge
    //----------------------------------------------------------------------
    task automatic checkWord(input string name, input logic [9:0] actual,
                             input logic [9:0] expected);
        checkCount++;
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("Fail %s at %0t ns: expected 0x%03h, actual 0x%03h",
                     name, $time, expected, actual);
        end
    endtask

    always @(negedge wPixelClk)
    begin
        checkWord("tmdsCh0", tmdsCh0, expCh0);
        checkWord("tmdsCh1", tmdsCh1, expCh1);
        checkWord("tmdsCh2", tmdsCh2, expCh2);
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial
    begin
        int          i;
        int          frames;
        logic [31:0] randWord;
        wPixelClk  = 1'b0;
        arstN      = 1'b0;
        patternSel = 2'd0;
        solidColor = 24'h000000;
        seed       = 32'h40a938c4;
        errorCount = 0;
        checkCount = 0;
        limitReady = 1'b0;
        for (i = 0; i < 4 * maxCases; i++)
        begin
            caseWords[i] = '0;          // Zero frame count ends the list
        end
        $readmemh("verif/hdmiVideo_testdata.txt", caseWords);
        numCases    = 0;
        totalFrames = 0;
        while ((numCases < maxCases) && (caseWords[4*numCases+3] != 0))
        begin
            totalFrames = totalFrames + int'(caseWords[4*numCases+3]);
            numCases++;
        end
        watchdogNs = longint'(totalFrames + 2) * longint'(frameCycles) * longint'(clkPeriod);
        limitReady = 1'b1;
        if (numCases == 0)
        begin
            errorCount++;
            $display("No test cases found in the data file");
        end

        repeat (3) @(posedge wPixelClk);
        @(negedge wPixelClk);
        arstN = 1'b1;
        repeat (frameCycles / 2) @(negedge wPixelClk);     // Mid-frame

        for (i = 0; i < numCases; i++)
        begin
            patternSel = caseWords[4*i][1:0];
            if (caseWords[4*i+1][0])
            begin
                randWord   = $random(seed);
                solidColor = randWord[23:0];
            end
            else
            begin
                solidColor = caseWords[4*i+2][23:0];
            end
            frames = int'(caseWords[4*i+3]);
            $display("Case %0d: pattern %0d, colour 0x%06h, %0d frame(s)",
                     i, patternSel, solidColor, frames);
            repeat (frames * frameCycles) @(negedge wPixelClk);   // Stays mid-frame
        end
        @(posedge wPixelClk);   // Last falling edge word check is complete

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog allows the frames in the file plus two
    initial
    begin
        wait (limitReady);
        #(watchdogNs);
        $display("Timeout: the run did not end within %0d ns", watchdogNs);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verif/hdmiVideo_testdata.txt */
// Columns: pattern (0 solid, 1 bars, 2 grid, 3 gradient), random flag (1 takes the
// colour from the seeded generator), colour RRGGBB, frame count
0 0 FFFFFF 1
0 0 000000 1
0 0 123456 1
0 0 80FF01 1
0 1 000000 1
0 1 000000 1
0 1 000000 2
1 0 000000 2
0 0 5A0FC3 1
2 0 000000 1
3 0 000000 2
1 0 000000 1
2 0 000000 1
0 1 000000 1
3 0 000000 1
0 0 F0F0F0 1
1 0 000000 1
2 0 000000 1
0 1 000000 1
3 0 000000 1
0 0 0F00AA 1

/* hdmiVideo.f */
+incdir+verif
design/hdmiVideoPkg.sv
design/dispTiming.sv
design/pixelGen.sv
design/tmdsEncoder.sv
design/hdmiVideoTop.sv
verif/hdmiVideoTb.sv

/* run.sh */
#!/bin/sh
# Build and run the HDMI video path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f hdmiVideo.f --top-module hdmiVideoTb -Mdir obj_dir
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOut=$(./obj_dir/VhdmiVideoTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
